// ==== files.f ====
verilog/iob_bus_pkg.sv
verilog/sram_pkg.sv
verilog/iob_bus_if.sv
verilog/merge_select.sv
verilog/sram_slave.sv
verilog/merge_route.sv
verilog/merge_sram_top.sv
tests/tb_merge_sram.sv

// ==== Bender.yml ====
package:
  name: merge_sram

sources:
  # Packages first, then the bus interface and the design modules.
  - files:
      - verilog/iob_bus_pkg.sv
      - verilog/sram_pkg.sv
      - verilog/iob_bus_if.sv
      - verilog/merge_select.sv
      - verilog/sram_slave.sv
      - verilog/merge_route.sv
      - verilog/merge_sram_top.sv

  # Simulation only.
  - target: test
    files:
      - tests/tb_merge_sram.sv

// ==== tests/tb_merge_sram.sv ====
module tb_merge_sram;

   localparam int aw          = iob_bus_pkg::addr_w;
   localparam int dw          = iob_bus_pkg::data_w;
   localparam int sw          = iob_bus_pkg::strb_w;
   localparam int nm          = iob_bus_pkg::n_masters;
   localparam int tx_w        = sw + dw + aw;
   localparam int list_len    = 32;
   localparam int pool_n      = 8;
   localparam int n_trans     = 72;
   localparam int cycle_limit = n_trans * 4 + 200;

   logic clk = 1'b1;
   logic arst_n;

   logic          m_avalid [nm];
   logic [aw-1:0] m_addr   [nm];
   logic [dw-1:0] m_wdata  [nm];
   logic [sw-1:0] m_wstrb  [nm];
   logic [dw-1:0] m_rdata  [nm];
   logic          m_rvalid [nm];
   logic          m_ready  [nm];

   // Per-master transaction lists. Each record is {wstrb, wdata, addr}.
   logic [tx_w-1:0] tx_list [nm][list_len];
   int              tx_cnt  [nm];
   int              gap_cfg [nm];
   logic [aw-1:0]   pool    [pool_n];

   // Reference memory and the response expected in the next cycle.
   logic [dw-1:0] ref_mem [sram_pkg::depth];
   logic          rd_pending = 1'b0;
   int            rd_owner   = 0;
   logic [dw-1:0] rd_expect  = '0;
   logic          wr_prev    = 1'b0;
   int            rd_planned = 0;
   int            rd_checked = 0;
   int            cycle_cnt  = 0;

   merge_sram_top dut_i (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .m_avalid_i (m_avalid),
      .m_addr_i   (m_addr),
      .m_wdata_i  (m_wdata),
      .m_wstrb_i  (m_wstrb),
      .m_rdata_o  (m_rdata),
      .m_rvalid_o (m_rvalid),
      .m_ready_o  (m_ready)
   );

   always #50 clk = ~clk;

   // ****************************************
   // Reference model
   // ****************************************

   // Byte lanes with a strobe bit take the new data and the others keep the old word.
   function automatic logic [dw-1:0] byte_merge(input logic [dw-1:0] old_word,
                                                input logic [dw-1:0] new_word,
                                                input logic [sw-1:0] strb);
      logic [dw-1:0] res;
      res = old_word;
      for (int i = 0; i < sw; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return res;
   endfunction

   // The highest requesting index wins. Master 0 is the answer when nobody requests.
   function automatic logic [iob_bus_pkg::sel_w-1:0] expected_winner(input logic [nm-1:0] av);
      for (int i = nm - 1; i >= 0; i--) begin
         if (av[i]) begin
            return iob_bus_pkg::sel_w'(i);
         end
      end
      return '0;
   endfunction

   // ****************************************
   // Compare tasks
   // ****************************************

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("TB FAILED");
      $fatal(1, "Simulation stopped.");
   endtask

   task automatic check_data(input logic [dw-1:0] got, input logic [dw-1:0] exp,
                             input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0t: %s, got %h, expected %h",
                                     $time, what, got, exp));
      end
   endtask

   task automatic check_sel(input logic [iob_bus_pkg::sel_w-1:0] got,
                            input logic [iob_bus_pkg::sel_w-1:0] exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0t: %s, got master %0d, expected master %0d",
                                     $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("Fail at %0t: %s, got %b, expected %b",
                                     $time, what, got, exp));
      end
   endtask

   // ****************************************
   // Response checker
   // ****************************************

   always @(posedge clk) begin : check_responses
      logic [nm-1:0]                 av_vec;
      logic [iob_bus_pkg::sel_w-1:0] win;
      logic                          exp_ready;
      int                            idx;
      for (int b = 0; b < nm; b++) begin
         av_vec[b] = m_avalid[b];
      end
      win = expected_winner(av_vec);
      if (!arst_n) begin
         for (int b = 0; b < nm; b++) begin
            check_flag(m_rvalid[b], 1'b0, $sformatf("rvalid of master %0d in reset", b));
            check_flag(m_ready[b], 1'b1, $sformatf("ready of idle master %0d in reset", b));
         end
         rd_pending = 1'b0;
         wr_prev    = 1'b0;
      end else begin
         // A read accepted in the previous cycle returns only to its owner.
         for (int b = 0; b < nm; b++) begin
            check_flag(m_rvalid[b], rd_pending && (b == rd_owner),
                       $sformatf("rvalid of master %0d", b));
            if (rd_pending && (b != rd_owner)) begin
               check_data(m_rdata[b], '0, $sformatf("rdata of idle master %0d", b));
            end
         end
         if (rd_pending) begin
            check_data(m_rdata[rd_owner], rd_expect,
                       $sformatf("read data of master %0d", rd_owner));
            rd_checked = rd_checked + 1;
         end

         // Among the requesters only the arbitration winner may see ready.
         for (int b = 0; b < nm; b++) begin
            if (m_avalid[b] && m_ready[b]) begin
               check_sel(iob_bus_pkg::sel_w'(b), win, "accepted master");
            end
         end

         // The cycle after a write is a recovery cycle for everybody.
         for (int b = 0; b < nm; b++) begin
            exp_ready = !wr_prev && (!m_avalid[b] || (b == int'(win)));
            check_flag(m_ready[b], exp_ready, $sformatf("ready of master %0d", b));
         end

         rd_pending = 1'b0;
         wr_prev    = 1'b0;
         for (int b = 0; b < nm; b++) begin
            if (m_avalid[b] && m_ready[b]) begin
               idx = int'(m_addr[b] >> 2) % sram_pkg::depth;
               if (m_wstrb[b] != '0) begin
                  ref_mem[idx] = byte_merge(ref_mem[idx], m_wdata[b], m_wstrb[b]);
                  wr_prev      = 1'b1;
               end else begin
                  rd_pending = 1'b1;
                  rd_owner   = b;
                  rd_expect  = ref_mem[idx];
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles.",
                                     cycle_limit));
      end
   end

   // ****************************************
   // Stimulus
   // ****************************************

   task automatic add_tx(input int m, input logic [aw-1:0] addr, input logic [dw-1:0] wdata,
                         input logic [sw-1:0] wstrb);
      tx_list[m][tx_cnt[m]] = {wstrb, wdata, addr};
      tx_cnt[m] = tx_cnt[m] + 1;
      if (wstrb == '0) begin
         rd_planned = rd_planned + 1;
      end
   endtask

   // Holds each request until it is accepted and then idles for gap cycles.
   task automatic drive_master(input int m, input int gap);
      for (int i = 0; i < tx_cnt[m]; i++) begin
         @(negedge clk);
         m_addr[m]   = tx_list[m][i][aw-1:0];
         m_wdata[m]  = tx_list[m][i][aw +: dw];
         m_wstrb[m]  = tx_list[m][i][aw + dw +: sw];
         m_avalid[m] = 1'b1;
         do begin
            @(posedge clk);
         end while (!m_ready[m]);
         if (gap > 0) begin
            @(negedge clk);
            m_avalid[m] = 1'b0;
            repeat (gap - 1) @(negedge clk);
         end
      end
      @(negedge clk);
      m_avalid[m] = 1'b0;
      m_wstrb[m]  = '0;
   endtask

   task automatic run_phase();
      for (int m = 0; m < nm; m++) begin
         automatic int mm = m;
         fork
            drive_master(mm, gap_cfg[mm]);
         join_none
      end
      wait fork;
      repeat (2) @(negedge clk);
      for (int m = 0; m < nm; m++) begin
         tx_cnt[m]  = 0;
         gap_cfg[m] = 0;
      end
   endtask

   initial begin : main
      int hi;
      void'($urandom(40));
      hi     = nm - 1;
      arst_n = 1'b1;
      for (int m = 0; m < nm; m++) begin
         m_avalid[m] = 1'b0;
         m_addr[m]   = '0;
         m_wdata[m]  = '0;
         m_wstrb[m]  = '0;
         tx_cnt[m]   = 0;
         gap_cfg[m]  = 0;
      end
      for (int k = 0; k < pool_n; k++) begin
         pool[k] = aw'($urandom);
      end

      @(negedge clk);
      arst_n = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;

      // Master 0 alone writes full words and reads them back.
      for (int k = 0; k < pool_n; k++) begin
         add_tx(0, pool[k], dw'($urandom), {sw{1'b1}});
      end
      for (int k = 0; k < pool_n; k++) begin
         add_tx(0, pool[k], '0, '0);
      end
      run_phase();

      // Partial strobes leave the other lanes untouched.
      for (int k = 0; k < pool_n; k++) begin
         add_tx(0, pool[k], dw'($urandom), sw'($urandom % 14 + 1));
      end
      for (int k = 0; k < pool_n; k++) begin
         add_tx(0, pool[k], '0, '0);
      end
      run_phase();

      // Both masters start in the same cycle and the top index goes first.
      for (int k = 0; k < 4; k++) begin
         add_tx(0, pool[k], dw'($urandom), (k % 2 == 0) ? {sw{1'b1}} : {sw{1'b0}});
         add_tx(hi, pool[k + 4], dw'($urandom), (k % 2 == 0) ? {sw{1'b1}} : {sw{1'b0}});
      end
      run_phase();

      // A one-cycle gap on the top master interleaves the reads.
      for (int k = 0; k < pool_n; k++) begin
         add_tx(0, pool[k], '0, '0);
         add_tx(hi, pool[pool_n - 1 - k], '0, '0);
      end
      gap_cfg[hi] = 1;
      run_phase();

      // Both masters write and then each one reads back the words of the other.
      for (int k = 0; k < 4; k++) begin
         add_tx(0, pool[k], dw'($urandom), sw'($urandom % 15 + 1));
         add_tx(hi, pool[k + 4], dw'($urandom), sw'($urandom % 15 + 1));
      end
      for (int k = 0; k < 4; k++) begin
         add_tx(0, pool[k + 4], '0, '0);
         add_tx(hi, pool[k], '0, '0);
      end
      gap_cfg[hi] = 1;
      run_phase();

      if (rd_checked != rd_planned) begin
         stop_with_failure($sformatf("Only %0d of %0d read responses were seen.",
                                     rd_checked, rd_planned));
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// ==== verilog/merge_sram_top.sv ====
// Several native bus masters sharing one on-chip memory.
// The arbiter picks a master, its request goes straight through to the memory
// in the same cycle, and the response is routed back to it a cycle later.
module merge_sram_top (
   input  logic                            clk_i,
   input  logic                            arst_n_i,

   // Master requests.
   input  logic                            m_avalid_i [iob_bus_pkg::n_masters],
   input  logic [iob_bus_pkg::addr_w-1:0]  m_addr_i   [iob_bus_pkg::n_masters],
   input  logic [iob_bus_pkg::data_w-1:0]  m_wdata_i  [iob_bus_pkg::n_masters],
   input  logic [iob_bus_pkg::strb_w-1:0]  m_wstrb_i  [iob_bus_pkg::n_masters],

   // Master responses.
   output logic [iob_bus_pkg::data_w-1:0]  m_rdata_o  [iob_bus_pkg::n_masters],
   output logic                            m_rvalid_o [iob_bus_pkg::n_masters],
   output logic                            m_ready_o  [iob_bus_pkg::n_masters]
);

   logic [iob_bus_pkg::sel_w-1:0] sel;
   logic [iob_bus_pkg::sel_w-1:0] sel_q;

   // Link between the arbiter and the memory.
   iob_bus_if slv_bus ();

   // ****************************************
   // Arbitration
   // ****************************************

   merge_select u_merge_select (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .m_avalid_i  (m_avalid_i),
      .slv_ready_i (slv_bus.ready),
      .sel_o       (sel),
      .sel_q_o     (sel_q)
   );

   // ****************************************
   // Request multiplexer
   // ****************************************

   // The chosen master drives the slave without a register stage.
   assign slv_bus.avalid = m_avalid_i[sel];
   assign slv_bus.addr   = m_addr_i[sel];
   assign slv_bus.wdata  = m_wdata_i[sel];
   assign slv_bus.wstrb  = m_wstrb_i[sel];

   // ****************************************
   // Memory
   // ****************************************

   sram_slave u_sram_slave (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .bus      (slv_bus.slave)
   );

   // ****************************************
   // Response routing
   // ****************************************

   merge_route u_merge_route (
      .m_avalid_i   (m_avalid_i),
      .sel_i        (sel),
      .sel_q_i      (sel_q),
      .slv_ready_i  (slv_bus.ready),
      .slv_rdata_i  (slv_bus.rdata),
      .slv_rvalid_i (slv_bus.rvalid),
      .m_ready_o    (m_ready_o),
      .m_rdata_o    (m_rdata_o),
      .m_rvalid_o   (m_rvalid_o)
   );

endmodule

// ==== verilog/merge_route.sv ====
// Sends the slave's response back to the masters.
// Ready is shared out in the request cycle. Read data follows one cycle later
// and belongs to the master selected when the read was accepted.
module merge_route (
   input  logic                            m_avalid_i  [iob_bus_pkg::n_masters],
   input  logic [iob_bus_pkg::sel_w-1:0]   sel_i,
   input  logic [iob_bus_pkg::sel_w-1:0]   sel_q_i,
   input  logic                            slv_ready_i,
   input  logic [iob_bus_pkg::data_w-1:0]  slv_rdata_i,
   input  logic                            slv_rvalid_i,
   output logic                            m_ready_o   [iob_bus_pkg::n_masters],
   output logic [iob_bus_pkg::data_w-1:0]  m_rdata_o   [iob_bus_pkg::n_masters],
   output logic                            m_rvalid_o  [iob_bus_pkg::n_masters]
);

   for (genvar a = 0; a < iob_bus_pkg::n_masters; a++) begin : g_master

      logic granted;
      logic owner;

      assign granted = (sel_i == iob_bus_pkg::sel_w'(a));
      assign owner   = (sel_q_i == iob_bus_pkg::sel_w'(a));

      // An idle master simply sees the slave's ready, so it can start at once.
      // A requesting master that lost arbitration is held off.
      always_comb begin
         if (granted || !m_avalid_i[a]) begin
            m_ready_o[a] = slv_ready_i;
         end else begin
            m_ready_o[a] = 1'b0;
         end
      end

      // Responses only reach the owner of the previous cycle.
      always_comb begin
         if (owner) begin
            m_rdata_o[a]  = slv_rdata_i;
            m_rvalid_o[a] = slv_rvalid_i;
         end else begin
            m_rdata_o[a]  = '0;
            m_rvalid_o[a] = 1'b0;
         end
      end

   end

endmodule

// ==== verilog/sram_slave.sv ====
// Single-port word memory on the native bus.
// Reads take one cycle. Every accepted write costs one extra cycle,
// during which ready is low and no new request is taken.
module sram_slave (
   input  logic       clk_i,
   input  logic       arst_n_i,
   iob_bus_if.slave   bus
);

   sram_pkg::sram_word_t mem [sram_pkg::depth];

   logic [sram_pkg::word_addr_w-1:0] word_idx;
   sram_pkg::sram_word_t             wr_word;
   logic                             accept;
   logic                             is_write;

   logic [iob_bus_pkg::data_w-1:0]   rdata_q;
   logic                             rvalid_q;
   logic                             ready_q;

   // ****************************************
   // Request decode
   // ****************************************

   // Byte address bits 1:0 select a lane and are covered by the strobe.
   assign word_idx = bus.addr[sram_pkg::word_addr_w+1:2];

   assign accept   = bus.avalid && bus.ready;

   // An all-zero strobe marks a read.
   assign is_write = |bus.wstrb;

   assign wr_word.word = bus.wdata;

   // ****************************************
   // Memory array
   // ****************************************

   // Only lanes with their strobe bit set are replaced.
   always_ff @(posedge clk_i) begin
      if (accept && is_write) begin
         for (int i = 0; i < iob_bus_pkg::strb_w; i++) begin
            if (bus.wstrb[i]) begin
               mem[word_idx].bytes[i] <= wr_word.bytes[i];
            end
         end
      end
   end

   // Read data is captured in the acceptance cycle and shown one cycle later.
   always_ff @(posedge clk_i) begin
      if (accept && !is_write) begin
         rdata_q <= mem[word_idx].word;
      end
   end

   // ****************************************
   // Handshake control
   // ****************************************

   // Ready drops for the cycle after a write and comes back on its own,
   // since no request can be accepted while it is low.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ready_q  <= 1'b1;
         rvalid_q <= 1'b0;
      end else begin
         ready_q  <= !(accept && is_write);
         rvalid_q <= accept && !is_write;
      end
   end

   assign bus.ready  = ready_q;
   assign bus.rvalid = rvalid_q;
   assign bus.rdata  = rdata_q;

endmodule

// ==== verilog/merge_select.sv ====
// Picks which master is connected to the slave.
// The highest requesting index wins. While the slave stalls the choice is frozen,
// so a request that is already on the bus cannot be swapped for another one.
module merge_select (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            m_avalid_i [iob_bus_pkg::n_masters],
   input  logic                            slv_ready_i,
   output logic [iob_bus_pkg::sel_w-1:0]   sel_o,
   output logic [iob_bus_pkg::sel_w-1:0]   sel_q_o
);

   logic [iob_bus_pkg::sel_w-1:0] sel;
   logic [iob_bus_pkg::sel_w-1:0] sel_q;

   // ****************************************
   // Priority encoder
   // ****************************************

   // Later iterations overwrite earlier ones, so the top index has priority.
   // With nobody requesting the selection falls back to master 0.
   always_comb begin
      if (slv_ready_i) begin
         sel = '0;
         for (int k = 0; k < iob_bus_pkg::n_masters; k++) begin
            if (m_avalid_i[k]) begin
               sel = iob_bus_pkg::sel_w'(k);
            end
         end
      end else begin
         sel = sel_q;
      end
   end

   // ****************************************
   // Selection register
   // ****************************************

   // The registered copy names the master that owns the response
   // returned in the next cycle.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
      end else begin
         sel_q <= sel;
      end
   end

   assign sel_o   = sel;
   assign sel_q_o = sel_q;

endmodule

// ==== verilog/iob_bus_if.sv ====
// One native bus link between a requester and a responder.
// A request is accepted when avalid and ready are both high.
// A read returns rdata together with a single rvalid pulse one cycle later.
interface iob_bus_if;

   // Request side.
   logic                              avalid;
   logic [iob_bus_pkg::addr_w-1:0]    addr;
   logic [iob_bus_pkg::data_w-1:0]    wdata;
   logic [iob_bus_pkg::strb_w-1:0]    wstrb;

   // Response side.
   logic [iob_bus_pkg::data_w-1:0]    rdata;
   logic                              rvalid;
   logic                              ready;

   modport master (
      output avalid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  rvalid,
      input  ready
   );

   modport slave (
      input  avalid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output rvalid,
      output ready
   );

endinterface

// ==== verilog/sram_pkg.sv ====
// ****************************************
// On-chip memory organisation
// ****************************************

package sram_pkg;

   // Number of data words held by the memory.
   localparam int depth = 1024;

   // Word index width. The index comes from byte address bits 11 down to 2.
   localparam int word_addr_w = $clog2(depth);

   // A memory word is seen as one value or as separate byte lanes.
   // Writes merge lanes under the strobe, reads return the whole word.
   typedef union packed {
      logic [iob_bus_pkg::data_w-1:0]       word;
      logic [iob_bus_pkg::strb_w-1:0][7:0] bytes;
   } sram_word_t;

endpackage

// ==== verilog/iob_bus_pkg.sv ====
// ****************************************
// Native bus dimensions
// ****************************************

package iob_bus_pkg;

   // Number of masters that share the slave. Values 2 to 4 are supported.
   localparam int n_masters = 2;

   // Data path width in bits.
   localparam int data_w = 32;

   // Byte address width. It covers the whole 4 KiB memory.
   localparam int addr_w = 12;

   // One write strobe bit per data byte.
   localparam int strb_w = data_w / 8;

   // Width of a master index.
   // A single master still needs one bit so the selector stays a real vector.
   localparam int sel_w = (n_masters > 1) ? $clog2(n_masters) : 1;

endpackage
